// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module tb_dual_issue -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "run.sh: pass" ||
{ echo "run.sh: fail"; exit 1; }

// File: src/alu_branch_pipe.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module alu_branch_pipe (
  input  logic                      clk,
  input  logic                      rst,
  input  issue_pkg::inst_t          inst,
  output logic [`REG_ADDR_BITS-1:0] rd_addr0,
  output logic [`REG_ADDR_BITS-1:0] rd_addr1,
  input  logic [`INST_WIDTH-1:0]    rd_data0,
  input  logic [`INST_WIDTH-1:0]    rd_data1,
  output logic                      wr_en,
  output logic [`REG_ADDR_BITS-1:0] wr_addr,
  output logic [`INST_WIDTH-1:0]    wr_data,
  output logic                      redirect,
  output logic [`PAIR_BITS-1:0]     target_pair,
  output logic                      halted
);

  import issue_pkg::*;

  logic [`OP_CODE_BITS-1:0] opcode;
  logic                     is_imm;
  logic                     is_je;
  logic                     is_halt;
  logic [`INST_WIDTH-1:0]   imm_ext;
  logic                     halted_q;

  assign opcode  = inst.r.opcode;
  assign is_imm  = (opcode[5:4] == 2'b01);
  assign is_je   = (opcode == 6'b110001);
  assign is_halt = (opcode == 6'b111111);
  assign imm_ext = {{(`INST_WIDTH-`IMM_BITS){inst.i.imm[`IMM_BITS-1]}}, inst.i.imm};

  assign rd_addr0 = inst.r.rs;
  assign rd_addr1 = is_je ? inst.r.rd : inst.r.rt; // je compares rd with rs.

  assign wr_en   = ~opcode[5];
  assign wr_addr = inst.r.rd; // same field in both forms.
  assign wr_data = alu_result(opcode, rd_data0, is_imm ? imm_ext : rd_data1);

  assign redirect    = (opcode == 6'b110000) || (is_je && rd_data0 == rd_data1);
  assign target_pair = inst.i.imm[`PAIR_BITS-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      halted_q <= 1'b0;
    end else if (is_halt) begin
      halted_q <= 1'b1;
    end
  end

  // rises in the halt cycle so fetch stops at the next edge.
  assign halted = halted_q | is_halt;

endmodule

// File: src/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// instruction word and opcode field.
`define INST_WIDTH      32
`define OP_CODE_BITS    6
`define OPCODE_MSB      31
`define OPCODE_LSB      26

// register file.
`define REG_COUNT       16
`define REG_ADDR_BITS   4

// memories, two instructions per pair.
`define IMEM_WORDS      64
`define IMEM_ADDR_BITS  6
`define PAIR_BITS       5
`define DMEM_WORDS      64
`define DMEM_ADDR_BITS  6

`define IMM_BITS        18
`define NOP_INSTRUCTION 32'h0000_0000

`endif

// File: src/data_mem_arbiter.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module data_mem_arbiter (
  input  logic                       clk,
  input  logic                       rst,
  input  issue_pkg::dmem_req_t       mem_req,
  output logic [`INST_WIDTH-1:0]     mem_rdata,
  input  logic                       host_rd,
  input  logic                       host_wr,
  input  logic [`DMEM_ADDR_BITS-1:0] host_addr,
  input  logic [`INST_WIDTH-1:0]     host_wdata,
  output logic [`INST_WIDTH-1:0]     host_rdata,
  output logic                       host_done
);

  logic [`INST_WIDTH-1:0]     dmem [`DMEM_WORDS];
  logic                       pend_rd;
  logic                       pend_wr;
  logic [`DMEM_ADDR_BITS-1:0] pend_addr;
  logic [`INST_WIDTH-1:0]     pend_wdata;
  logic                       pend_valid;
  logic                       pipe_grant;
  logic                       host_grant;
  logic                       req_wr;
  logic [`DMEM_ADDR_BITS-1:0] req_addr;
  logic [`INST_WIDTH-1:0]     req_wdata;

  assign pend_valid = pend_rd | pend_wr;
  assign pipe_grant = mem_req.read | mem_req.write; // pipe b always first.
  assign host_grant = (pend_valid | host_rd | host_wr) & ~pipe_grant;

  assign req_wr    = pend_valid ? pend_wr    : host_wr;
  assign req_addr  = pend_valid ? pend_addr  : host_addr;
  assign req_wdata = pend_valid ? pend_wdata : host_wdata;

  assign mem_rdata  = dmem[mem_req.addr];
  assign host_rdata = dmem[req_addr];
  assign host_done  = host_grant;

  always_ff @(posedge clk) begin
    if (mem_req.write) begin
      dmem[mem_req.addr] <= mem_req.wdata;
    end else if (host_grant && req_wr) begin
      dmem[req_addr] <= req_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_rd <= 1'b0;
      pend_wr <= 1'b0;
    end else if (host_grant) begin
      pend_rd <= 1'b0;
      pend_wr <= 1'b0;
    end else if (host_rd || host_wr) begin
      pend_rd <= host_rd; // wait for a free cycle.
      pend_wr <= host_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (!host_grant && (host_rd || host_wr)) begin
      pend_addr  <= host_addr;
      pend_wdata <= host_wdata;
    end
  end

endmodule

// File: src/dual_issue_core.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module dual_issue_core (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       run,
  input  logic                       imem_we,
  input  logic [`IMEM_ADDR_BITS-1:0] imem_addr,
  input  logic [`INST_WIDTH-1:0]     imem_wdata,
  input  logic                       host_rd,
  input  logic                       host_wr,
  input  logic [`DMEM_ADDR_BITS-1:0] host_addr,
  input  logic [`INST_WIDTH-1:0]     host_wdata,
  output logic [`INST_WIDTH-1:0]     host_rdata,
  output logic                       host_done,
  output logic                       halted,
  output issue_pkg::issue_trace_t    trace
);

  import issue_pkg::*;

  inst_t                     pair0, pair1, slot0, slot1;
  logic                      fetch_stall, pair_valid, stall, first;
  logic                      redirect;
  logic [`PAIR_BITS-1:0]     target_pair;
  logic [`REG_ADDR_BITS-1:0] a_rd_addr0, a_rd_addr1, b_rd_addr0, b_rd_addr1;
  logic [`INST_WIDTH-1:0]    a_rd_data0, a_rd_data1, b_rd_data0, b_rd_data1;
  logic                      a_wr_en, b_wr_en;
  logic [`REG_ADDR_BITS-1:0] a_wr_addr, b_wr_addr;
  logic [`INST_WIDTH-1:0]    a_wr_data, b_wr_data;
  dmem_req_t                 mem_req;
  logic [`INST_WIDTH-1:0]    mem_rdata;

  assign trace = {pair_valid, first, slot0, slot1};

  fetch_unit u_fetch (
    .clk(clk), .rst(rst), .run(run & ~halted),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
    .stall(stall), .redirect(redirect), .target_pair(target_pair),
    .pair0(pair0), .pair1(pair1), .fetch_stall(fetch_stall), .pair_valid(pair_valid)
  );

  steer u_steer (
    .instruction0_in(pair0), .instruction1_in(pair1), .fetch_stall(fetch_stall),
    .instruction0_out(slot0), .instruction1_out(slot1), .stall(stall), .first(first)
  );

  alu_branch_pipe u_pipe_a (
    .clk(clk), .rst(rst), .inst(slot0),
    .rd_addr0(a_rd_addr0), .rd_addr1(a_rd_addr1),
    .rd_data0(a_rd_data0), .rd_data1(a_rd_data1),
    .wr_en(a_wr_en), .wr_addr(a_wr_addr), .wr_data(a_wr_data),
    .redirect(redirect), .target_pair(target_pair), .halted(halted)
  );

  load_store_pipe u_pipe_b (
    .inst(slot1),
    .rd_addr0(b_rd_addr0), .rd_addr1(b_rd_addr1),
    .rd_data0(b_rd_data0), .rd_data1(b_rd_data1),
    .wr_en(b_wr_en), .wr_addr(b_wr_addr), .wr_data(b_wr_data),
    .mem_req(mem_req), .mem_rdata(mem_rdata)
  );

  regfile u_regfile (
    .clk(clk), .rst(rst),
    .rd_addr0(a_rd_addr0), .rd_addr1(a_rd_addr1),
    .rd_addr2(b_rd_addr0), .rd_addr3(b_rd_addr1),
    .rd_data0(a_rd_data0), .rd_data1(a_rd_data1),
    .rd_data2(b_rd_data0), .rd_data3(b_rd_data1),
    .wr_en_a(a_wr_en), .wr_addr_a(a_wr_addr), .wr_data_a(a_wr_data),
    .wr_en_b(b_wr_en), .wr_addr_b(b_wr_addr), .wr_data_b(b_wr_data)
  );

  data_mem_arbiter u_arbiter (
    .clk(clk), .rst(rst), .mem_req(mem_req), .mem_rdata(mem_rdata),
    .host_rd(host_rd), .host_wr(host_wr), .host_addr(host_addr),
    .host_wdata(host_wdata), .host_rdata(host_rdata), .host_done(host_done)
  );

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module fetch_unit (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       run,
  input  logic                       imem_we,
  input  logic [`IMEM_ADDR_BITS-1:0] imem_addr,
  input  logic [`INST_WIDTH-1:0]     imem_wdata,
  input  logic                       stall,
  input  logic                       redirect,
  input  logic [`PAIR_BITS-1:0]      target_pair,
  output issue_pkg::inst_t           pair0,
  output issue_pkg::inst_t           pair1,
  output logic                       fetch_stall,
  output logic                       pair_valid
);

  logic [`INST_WIDTH-1:0] imem [`IMEM_WORDS];
  logic [`PAIR_BITS-1:0]  pair_idx;
  logic [`PAIR_BITS-1:0]  fetch_idx;
  logic                   redirect_pend;
  logic [`PAIR_BITS-1:0]  pend_target;

  // a live redirect overrides one remembered from the first half.
  assign fetch_idx = redirect      ? target_pair :
                     redirect_pend ? pend_target : pair_idx;

  always_ff @(posedge clk) begin
    if (imem_we && !run) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pair_idx      <= '0;
      pair0         <= `NOP_INSTRUCTION;
      pair1         <= `NOP_INSTRUCTION;
      fetch_stall   <= 1'b0;
      pair_valid    <= 1'b0;
      redirect_pend <= 1'b0;
      pend_target   <= '0;
    end else if (!run) begin
      pair0         <= `NOP_INSTRUCTION; // index holds.
      pair1         <= `NOP_INSTRUCTION;
      fetch_stall   <= 1'b0;
      pair_valid    <= 1'b0;
      redirect_pend <= 1'b0;
    end else if (stall) begin
      fetch_stall <= 1'b1; // hold pair for second half.
      if (redirect) begin
        redirect_pend <= 1'b1;
        pend_target   <= target_pair;
      end
    end else begin
      fetch_stall   <= 1'b0;
      redirect_pend <= 1'b0;
      pair_valid    <= 1'b1;
      pair0         <= imem[{fetch_idx, 1'b0}];
      pair1         <= imem[{fetch_idx, 1'b1}];
      pair_idx      <= fetch_idx + 1'b1;
    end
  end

endmodule

// File: src/issue_pkg.sv
`include "core_defines.svh"

package issue_pkg;

  typedef struct packed {
    logic [`OP_CODE_BITS-1:0]  opcode;
    logic [`REG_ADDR_BITS-1:0] rd;
    logic [`REG_ADDR_BITS-1:0] rs;
    logic [`REG_ADDR_BITS-1:0] rt;
    logic [13:0]               unused;
  } r_fmt_t;

  typedef struct packed {
    logic [`OP_CODE_BITS-1:0]  opcode;
    logic [`REG_ADDR_BITS-1:0] rd;
    logic [`REG_ADDR_BITS-1:0] rs;
    logic [`IMM_BITS-1:0]      imm;
  } i_fmt_t;

  // register form for 00xxxx, immediate form otherwise.
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_t;

  typedef enum logic [1:0] {
    pipe_a = 2'd0,
    pipe_b = 2'd1,
    either = 2'd2
  } pipe_class_t;

  typedef struct packed {
    logic  valid;
    logic  first;
    inst_t slot0;
    inst_t slot1;
  } issue_trace_t;

  typedef struct packed {
    logic                       read;
    logic                       write;
    logic [`DMEM_ADDR_BITS-1:0] addr;
    logic [`INST_WIDTH-1:0]     wdata;
  } dmem_req_t;

  function automatic logic [`INST_WIDTH-1:0] alu_result(
    input logic [`OP_CODE_BITS-1:0] opcode,
    input logic [`INST_WIDTH-1:0]   a,
    input logic [`INST_WIDTH-1:0]   b
  );
    case (opcode[2:0])
      3'b001:  alu_result = a - b;
      3'b010:  alu_result = a & b;
      3'b011:  alu_result = a | b;
      3'b100:  alu_result = a ^ b;
      default: alu_result = a + b; // add, also nop.
    endcase
  endfunction

endpackage

// File: src/load_store_pipe.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module load_store_pipe (
  input  issue_pkg::inst_t          inst,
  output logic [`REG_ADDR_BITS-1:0] rd_addr0,
  output logic [`REG_ADDR_BITS-1:0] rd_addr1,
  input  logic [`INST_WIDTH-1:0]    rd_data0,
  input  logic [`INST_WIDTH-1:0]    rd_data1,
  output logic                      wr_en,
  output logic [`REG_ADDR_BITS-1:0] wr_addr,
  output logic [`INST_WIDTH-1:0]    wr_data,
  output issue_pkg::dmem_req_t      mem_req,
  input  logic [`INST_WIDTH-1:0]    mem_rdata
);

  import issue_pkg::*;

  logic [`OP_CODE_BITS-1:0] opcode;
  logic                     is_imm;
  logic                     is_lw;
  logic                     is_sw;
  logic [`INST_WIDTH-1:0]   imm_ext;
  logic [`INST_WIDTH-1:0]   eff_addr;

  assign opcode   = inst.r.opcode;
  assign is_imm   = opcode[5:4] != 2'b00;
  assign is_lw    = (opcode == 6'b100000);
  assign is_sw    = (opcode == 6'b100001);
  assign imm_ext  = {{(`INST_WIDTH-`IMM_BITS){inst.i.imm[`IMM_BITS-1]}}, inst.i.imm};
  assign eff_addr = rd_data0 + imm_ext;

  assign rd_addr0 = inst.r.rs;
  assign rd_addr1 = is_sw ? inst.i.rd : inst.r.rt; // store data comes from rd.

  assign mem_req.read  = is_lw;
  assign mem_req.write = is_sw;
  assign mem_req.addr  = eff_addr[`DMEM_ADDR_BITS-1:0]; // word address.
  assign mem_req.wdata = rd_data1;

  assign wr_en   = ~opcode[5] | is_lw;
  assign wr_addr = inst.r.rd;
  assign wr_data = is_lw ? mem_rdata
                         : alu_result(opcode, rd_data0, is_imm ? imm_ext : rd_data1);

endmodule

// File: src/regfile.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module regfile (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`REG_ADDR_BITS-1:0] rd_addr0,
  input  logic [`REG_ADDR_BITS-1:0] rd_addr1,
  input  logic [`REG_ADDR_BITS-1:0] rd_addr2,
  input  logic [`REG_ADDR_BITS-1:0] rd_addr3,
  output logic [`INST_WIDTH-1:0]    rd_data0,
  output logic [`INST_WIDTH-1:0]    rd_data1,
  output logic [`INST_WIDTH-1:0]    rd_data2,
  output logic [`INST_WIDTH-1:0]    rd_data3,
  input  logic                      wr_en_a,
  input  logic [`REG_ADDR_BITS-1:0] wr_addr_a,
  input  logic [`INST_WIDTH-1:0]    wr_data_a,
  input  logic                      wr_en_b,
  input  logic [`REG_ADDR_BITS-1:0] wr_addr_b,
  input  logic [`INST_WIDTH-1:0]    wr_data_b
);

  logic [`INST_WIDTH-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr_en_a) begin
        regs[wr_addr_a] <= wr_data_a;
      end
      if (wr_en_b) begin
        regs[wr_addr_b] <= wr_data_b; // pipe b wins a tie.
      end
    end
  end

  assign rd_data0 = (rd_addr0 == '0) ? '0 : regs[rd_addr0];
  assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
  assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];
  assign rd_data3 = (rd_addr3 == '0) ? '0 : regs[rd_addr3];

endmodule

// File: src/steer.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module steer (
  input  issue_pkg::inst_t instruction0_in,
  input  issue_pkg::inst_t instruction1_in,
  input  logic             fetch_stall,
  output issue_pkg::inst_t instruction0_out,
  output issue_pkg::inst_t instruction1_out,
  output logic             stall,
  output logic             first
);

  import issue_pkg::*;

  pipe_class_t class0;
  pipe_class_t class1;

  function automatic pipe_class_t classify(input logic [`OP_CODE_BITS-1:0] opcode);
    case (opcode[`OP_CODE_BITS-1 -: 2])
      2'b10:   classify = pipe_b; // lw, sw.
      2'b11:   classify = pipe_a; // jmp, je, halt.
      default: classify = either; // alu, reg or imm.
    endcase
  endfunction

  assign class0 = classify(instruction0_in.r.opcode);
  assign class1 = classify(instruction1_in.r.opcode);

  always_comb begin
    instruction0_out = instruction0_in;
    instruction1_out = instruction1_in;
    stall            = 1'b0;
    first            = 1'b0;

    case ({class0, class1})
      {pipe_a, pipe_a}: begin
        instruction1_out = `NOP_INSTRUCTION;
        if (fetch_stall) begin
          instruction0_out = instruction1_in; // younger half.
        end else begin
          stall = 1'b1;
        end
      end
      {pipe_b, pipe_b}: begin
        instruction0_out = `NOP_INSTRUCTION;
        first            = 1'b1;
        if (fetch_stall) begin
          instruction1_out = instruction1_in;
        end else begin
          instruction1_out = instruction0_in;
          stall            = 1'b1;
        end
      end
      {pipe_b, pipe_a},
      {pipe_b, either},
      {either, pipe_a}: begin
        instruction0_out = instruction1_in; // swapped.
        instruction1_out = instruction0_in;
        first            = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

// File: tb/dual_issue_sva.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module dual_issue_sva (
  input logic                 clk,
  input logic                 rst,
  input logic                 halted,
  input logic                 stall,
  input logic                 fetch_stall,
  input issue_pkg::inst_t     pair0,
  input issue_pkg::inst_t     pair1,
  input issue_pkg::inst_t     slot0,
  input issue_pkg::inst_t     slot1,
  input issue_pkg::dmem_req_t mem_req,
  input logic                 host_rd,
  input logic                 host_wr,
  input logic                 host_done
);

  logic mem_pair;
  logic pipe_busy;
  logic host_wait;

  assign mem_pair  = pair0.r.opcode[5:4] == 2'b10 && pair1.r.opcode[5:4] == 2'b10;
  assign pipe_busy = mem_req.read || mem_req.write;

  // host strobe still owed a done pulse.
  always_ff @(posedge clk) begin
    if (rst) begin
      host_wait <= 1'b0;
    end else if (host_done) begin
      host_wait <= 1'b0;
    end else if (host_rd || host_wr) begin
      host_wait <= 1'b1;
    end
  end

  // second half of a split never splits again.
  assert property (@(posedge clk) disable iff (rst || halted)
    stall |=> fetch_stall && !stall)
    else $error("split pair not held for exactly one second half");

  assert property (@(posedge clk) disable iff (rst)
    (mem_pair && !fetch_stall) |=>
      $past(slot0) == `NOP_INSTRUCTION && slot0 == `NOP_INSTRUCTION &&
      slot1 == $past(pair1))
    else $error("memory pair left an instruction in slot 0");

  assert property (@(posedge clk) disable iff (rst)
    pipe_busy |-> !host_done)
    else $error("host_done while pipe b holds the data memory");

  assert property (@(posedge clk) disable iff (rst)
    (host_wait && !pipe_busy) |-> host_done)
    else $error("held host request not served on a free cycle");

endmodule

bind dual_issue_core dual_issue_sva u_sva (
  .clk(clk), .rst(rst), .halted(halted), .stall(stall), .fetch_stall(fetch_stall),
  .pair0(pair0), .pair1(pair1), .slot0(slot0), .slot1(slot1),
  .mem_req(mem_req), .host_rd(host_rd), .host_wr(host_wr), .host_done(host_done)
);

// File: tb/tb_dual_issue.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module tb_dual_issue;

  import issue_pkg::*;

  localparam logic [5:0] op_add = 6'h00, op_sub = 6'h01, op_and = 6'h02;
  localparam logic [5:0] op_or = 6'h03, op_xor = 6'h04, op_addi = 6'h10;
  localparam logic [5:0] op_subi = 6'h11, op_xori = 6'h14, op_lw = 6'h20;
  localparam logic [5:0] op_sw = 6'h21, op_jmp = 6'h30, op_je = 6'h31;
  localparam logic [5:0] op_halt = 6'h3f;

  logic                       clk, rst, run, imem_we;
  logic [`IMEM_ADDR_BITS-1:0] imem_addr;
  logic [`INST_WIDTH-1:0]     imem_wdata;
  logic                       host_rd, host_wr, host_done, halted;
  logic [`DMEM_ADDR_BITS-1:0] host_addr;
  logic [`INST_WIDTH-1:0]     host_wdata, host_rdata;
  issue_trace_t               trace;

  logic [`INST_WIDTH-1:0] prog [`IMEM_WORDS];
  int                     prog_len;
  logic [31:0]            rand_state = 32'h4f60_cc37;
  int                     error_count, check_count;
  issue_trace_t           exp_q[$];
  issue_trace_t           got_q[$];
  logic                   capture_on;

  dual_issue_core dut (
    .clk(clk), .rst(rst), .run(run),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
    .host_rd(host_rd), .host_wr(host_wr), .host_addr(host_addr),
    .host_wdata(host_wdata), .host_rdata(host_rdata), .host_done(host_done),
    .halted(halted), .trace(trace)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    if (capture_on && trace.valid) begin
      got_q.push_back(trace);
    end
  end

  function logic [31:0] next_rand();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 17);
    rand_state = rand_state ^ (rand_state << 5);
    return rand_state;
  endfunction

  function logic [31:0] r_inst(input logic [5:0] op, input logic [3:0] rd,
                               input logic [3:0] rs, input logic [3:0] rt);
    return {op, rd, rs, rt, 14'd0};
  endfunction

  function logic [31:0] i_inst(input logic [5:0] op, input logic [3:0] rd,
                               input logic [3:0] rs, input logic [17:0] imm);
    return {op, rd, rs, imm};
  endfunction

  function pipe_class_t class_of(input logic [31:0] w);
    if (w[31:30] == 2'b10) return pipe_b;
    if (w[31:30] == 2'b11) return pipe_a;
    return either;
  endfunction

  // appends a pair and the trace entries the steering table predicts.
  function void emit(input logic [31:0] w0, input logic [31:0] w1);
    pipe_class_t c0, c1;
    c0 = class_of(w0);
    c1 = class_of(w1);
    prog[prog_len]     = w0;
    prog[prog_len + 1] = w1;
    prog_len           = prog_len + 2;
    if (c0 == pipe_a && c1 == pipe_a) begin
      exp_q.push_back({1'b1, 1'b0, w0, `NOP_INSTRUCTION});
      exp_q.push_back({1'b1, 1'b0, w1, `NOP_INSTRUCTION});
    end else if (c0 == pipe_b && c1 == pipe_b) begin
      exp_q.push_back({1'b1, 1'b1, `NOP_INSTRUCTION, w0});
      exp_q.push_back({1'b1, 1'b1, `NOP_INSTRUCTION, w1});
    end else if ((c0 == pipe_b) || (c0 == either && c1 == pipe_a)) begin
      exp_q.push_back({1'b1, 1'b1, w1, w0}); // swapped.
    end else begin
      exp_q.push_back({1'b1, 1'b0, w0, w1});
    end
  endfunction

  task check_word(input string name, input logic [`INST_WIDTH-1:0] exp_val,
                  input logic [`INST_WIDTH-1:0] act_val);
    check_count++;
    if (act_val !== exp_val) begin
      $display("ERR %s expected %h actual %h", name, exp_val, act_val);
      error_count++;
    end
  endtask

  task check_trace(input string name, input issue_trace_t exp_val,
                   input issue_trace_t act_val);
    check_count++;
    if (act_val !== exp_val) begin
      $display("ERR %s expected %h actual %h", name, exp_val, act_val);
      error_count++;
    end
  endtask

  task apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    prog_len = 0;
    exp_q.delete();
    got_q.delete();
  endtask

  task load_program();
    for (int i = 0; i < prog_len; i++) begin
      @(posedge clk);
      imem_we    <= 1'b1;
      imem_addr  <= i[5:0];
      imem_wdata <= prog[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
  endtask

  task host_access(input logic wr, input logic [5:0] addr,
                   input logic [31:0] wdata, output logic [31:0] rdata);
    logic done;
    int   n;
    @(posedge clk);
    host_rd    <= !wr;
    host_wr    <= wr;
    host_addr  <= addr;
    host_wdata <= wdata;
    @(negedge clk);
    done  = host_done;
    rdata = host_rdata;
    @(posedge clk);
    host_rd <= 1'b0;
    host_wr <= 1'b0;
    n = 0;
    while (!done && n < 100) begin
      @(negedge clk);
      done  = host_done;
      rdata = host_rdata;
      n++;
    end
    if (!done) begin
      $display("host access to word %0d never completed", addr);
      error_count++;
    end
  endtask

  task run_program();
    int n;
    @(posedge clk);
    run <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!halted && n < 300) begin
      @(negedge clk);
      n++;
    end
    if (!halted) begin
      $display("program did not reach halt in time");
      error_count++;
    end
    @(posedge clk);
    run <= 1'b0;
    @(posedge clk);
  endtask

  task test_alu();
    logic [31:0] a, b, r, v;
    logic [17:0] imm0, imm1, imm2;
    logic [31:0] exp_val [8];
    a = next_rand();
    b = next_rand();
    r = next_rand();
    imm0 = {1'b0, r[16:0]};
    r = next_rand();
    imm1 = {1'b0, r[16:0]};
    r = next_rand();
    imm2 = {1'b0, r[16:0]};
    apply_reset();
    emit(i_inst(op_lw, 1, 0, 0), `NOP_INSTRUCTION);
    emit(i_inst(op_lw, 2, 0, 1), `NOP_INSTRUCTION);
    emit(r_inst(op_add, 3, 1, 2), r_inst(op_sub, 4, 1, 2));
    emit(r_inst(op_and, 5, 1, 2), r_inst(op_or, 6, 1, 2));
    emit(r_inst(op_xor, 7, 1, 2), i_inst(op_addi, 8, 1, imm0));
    emit(i_inst(op_xori, 9, 2, imm1), i_inst(op_subi, 10, 1, imm2));
    for (int i = 0; i < 8; i++) begin
      if (i % 2 == 0) emit(i_inst(op_sw, 4'(3 + i), 0, 18'(16 + i)), `NOP_INSTRUCTION);
      else emit(`NOP_INSTRUCTION, i_inst(op_sw, 4'(3 + i), 0, 18'(16 + i)));
    end
    emit(op_halt << 26, `NOP_INSTRUCTION);
    load_program();
    host_access(1'b1, 0, a, v);
    host_access(1'b1, 1, b, v);
    run_program();
    exp_val = '{a + b, a - b, a & b, a | b, a ^ b,
                a + {14'd0, imm0}, b ^ {14'd0, imm1}, a - {14'd0, imm2}};
    for (int i = 0; i < 8; i++) begin
      host_access(1'b0, 6'(16 + i), 0, v);
      check_word($sformatf("alu result %0d", i), exp_val[i], v);
    end
  endtask

  task test_trace();
    logic [31:0] v;
    apply_reset();
    emit(i_inst(op_addi, 1, 0, 5), i_inst(op_addi, 2, 0, 7));
    emit(i_inst(op_je, 1, 0, 0), i_inst(op_je, 2, 0, 0));
    emit(i_inst(op_lw, 3, 0, 0), i_inst(op_je, 1, 0, 0));
    emit(i_inst(op_sw, 1, 0, 2), i_inst(op_sw, 2, 0, 3));
    emit(i_inst(op_sw, 2, 0, 4), i_inst(op_addi, 4, 0, 1));
    emit(i_inst(op_addi, 5, 0, 2), i_inst(op_je, 2, 0, 0));
    emit(i_inst(op_addi, 6, 0, 3), i_inst(op_sw, 1, 0, 5));
    emit(i_inst(op_je, 1, 0, 0), i_inst(op_addi, 7, 0, 4));
    emit(op_halt << 26, `NOP_INSTRUCTION);
    load_program();
    capture_on = 1'b1;
    run_program();
    capture_on = 1'b0;
    check_word("trace count", exp_q.size(), got_q.size());
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      check_trace($sformatf("trace %0d", i), exp_q[i], got_q[i]);
    end
    host_access(1'b0, 2, 0, v);
    check_word("trace sw first half", 32'd5, v);
    host_access(1'b0, 3, 0, v);
    check_word("trace sw second half", 32'd7, v);
  endtask

  task test_split();
    logic [31:0] a, v;
    a = next_rand();
    apply_reset();
    emit(i_inst(op_lw, 1, 0, 0), i_inst(op_sw, 1, 0, 1));
    emit(i_inst(op_jmp, 0, 0, 3), i_inst(op_addi, 5, 0, 99));
    emit(i_inst(op_addi, 6, 0, 1), `NOP_INSTRUCTION); // skipped by jmp.
    emit(i_inst(op_sw, 5, 0, 2), i_inst(op_sw, 6, 0, 3));
    emit(op_halt << 26, `NOP_INSTRUCTION);
    load_program();
    host_access(1'b1, 0, a, v);
    host_access(1'b1, 1, ~a, v);
    host_access(1'b1, 3, 32'hffff_ffff, v);
    run_program();
    host_access(1'b0, 1, 0, v);
    check_word("split lw then sw", a, v);
    host_access(1'b0, 2, 0, v);
    check_word("delay slot result", 32'd99, v);
    host_access(1'b0, 3, 0, v);
    check_word("skipped pair flag", 32'd0, v);
  endtask

  task test_branch();
    logic [31:0] a, v;
    a = next_rand();
    apply_reset();
    emit(i_inst(op_lw, 1, 0, 0), `NOP_INSTRUCTION);
    emit(i_inst(op_lw, 2, 0, 0), `NOP_INSTRUCTION);
    emit(i_inst(op_lw, 3, 0, 1), `NOP_INSTRUCTION);
    emit(i_inst(op_je, 1, 2, 5), `NOP_INSTRUCTION); // taken.
    emit(i_inst(op_addi, 6, 0, 1), `NOP_INSTRUCTION);
    emit(i_inst(op_je, 1, 3, 7), `NOP_INSTRUCTION); // not taken.
    emit(i_inst(op_addi, 7, 0, 1), `NOP_INSTRUCTION);
    emit(i_inst(op_sw, 6, 0, 2), i_inst(op_sw, 7, 0, 3));
    emit(op_halt << 26, `NOP_INSTRUCTION);
    load_program();
    host_access(1'b1, 0, a, v);
    host_access(1'b1, 1, a ^ 32'd1, v);
    run_program();
    host_access(1'b0, 2, 0, v);
    check_word("je taken flag", 32'd0, v);
    host_access(1'b0, 3, 0, v);
    check_word("je not taken path", 32'd1, v);
  endtask

  task test_host_stream();
    logic [31:0] r, v, rv;
    r = next_rand();
    v = {15'd0, r[16:0]};
    apply_reset();
    emit(i_inst(op_addi, 1, 0, v[17:0]), `NOP_INSTRUCTION);
    emit(i_inst(op_sw, 1, 0, 5), `NOP_INSTRUCTION);
    for (int k = 0; k < 10; k++) begin
      emit(i_inst(op_sw, 1, 0, 18'(6 + k)), `NOP_INSTRUCTION);
    end
    emit(op_halt << 26, `NOP_INSTRUCTION);
    load_program();
    fork
      run_program();
      begin
        repeat (4) @(posedge clk);
        host_access(1'b0, 5, 0, rv); // lands in the store stream.
      end
    join
    check_word("host read during stores", v, rv);
  endtask

  initial begin
    rst        = 1'b0;
    run        = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    host_rd    = 1'b0;
    host_wr    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    capture_on = 1'b0;
    error_count = 0;
    check_count = 0;
    prog_len    = 0;
    test_alu();
    test_trace();
    test_split();
    test_branch();
    test_host_stream();
    $display("checks %0d errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+src
src/issue_pkg.sv
src/fetch_unit.sv
src/steer.sv
src/alu_branch_pipe.sv
src/load_store_pipe.sv
src/regfile.sv
src/data_mem_arbiter.sv
src/dual_issue_core.sv
tb/dual_issue_sva.sv
tb/tb_dual_issue.sv
